//--- ps2_pkg.sv
package ps2_pkg;

	localparam logic [3:0] frame_bits = 4'd11;	// start, eight data, parity, stop.
	localparam logic [7:0] break_code = 8'hf0;
	localparam logic [7:0] ext_code = 8'he0;
	localparam logic [15:0] idle_timeout = 16'd2000;

	// key tracker states. the extended flag is kept apart from these.
	localparam logic [1:0] st_idle = 2'd0;
	localparam logic [1:0] st_held = 2'd1;
	localparam logic [1:0] st_break = 2'd2;
	localparam logic [1:0] st_ext = 2'd3;

	// scan code set 2, lower case only.
	function automatic logic [7:0] scan_to_ascii(input logic [7:0] code);
		logic [7:0] ch;
		case (code)
			8'h1c: ch = 8'h61;
			8'h32: ch = 8'h62;
			8'h21: ch = 8'h63;
			8'h23: ch = 8'h64;
			8'h24: ch = 8'h65;
			8'h2b: ch = 8'h66;
			8'h34: ch = 8'h67;
			8'h33: ch = 8'h68;
			8'h43: ch = 8'h69;
			8'h3b: ch = 8'h6a;
			8'h42: ch = 8'h6b;
			8'h4b: ch = 8'h6c;
			8'h3a: ch = 8'h6d;
			8'h31: ch = 8'h6e;
			8'h44: ch = 8'h6f;
			8'h4d: ch = 8'h70;
			8'h15: ch = 8'h71;
			8'h2d: ch = 8'h72;
			8'h1b: ch = 8'h73;
			8'h2c: ch = 8'h74;
			8'h3c: ch = 8'h75;
			8'h2a: ch = 8'h76;
			8'h1d: ch = 8'h77;
			8'h22: ch = 8'h78;
			8'h35: ch = 8'h79;
			8'h1a: ch = 8'h7a;
			8'h45: ch = 8'h30;
			8'h16: ch = 8'h31;
			8'h1e: ch = 8'h32;
			8'h26: ch = 8'h33;
			8'h25: ch = 8'h34;
			8'h2e: ch = 8'h35;
			8'h36: ch = 8'h36;
			8'h3d: ch = 8'h37;
			8'h3e: ch = 8'h38;
			8'h46: ch = 8'h39;
			8'h29: ch = 8'h20;	// space.
			8'h5a: ch = 8'h0d;	// enter gives carriage return.
			default: ch = 8'h00;
		endcase
		return ch;
	endfunction

endpackage

//--- disp_pkg.sv
package disp_pkg;

	localparam logic [2:0] num_digits = 3'd6;
	localparam logic [6:0] seg_blank = 7'h7f;	// segments are active low.

	// pattern bits are g down to a, a zero lights the segment.
	function automatic logic [6:0] hex_to_seg(input logic [3:0] value);
		logic [6:0] seg;
		case (value)
			4'h0: seg = 7'h40;
			4'h1: seg = 7'h79;
			4'h2: seg = 7'h24;
			4'h3: seg = 7'h30;
			4'h4: seg = 7'h19;
			4'h5: seg = 7'h12;
			4'h6: seg = 7'h02;
			4'h7: seg = 7'h78;
			4'h8: seg = 7'h00;
			4'h9: seg = 7'h10;
			4'ha: seg = 7'h08;
			4'hb: seg = 7'h03;	// lower case b so it differs from 8.
			4'hc: seg = 7'h46;
			4'hd: seg = 7'h21;
			4'he: seg = 7'h06;
			default: seg = 7'h0e;
		endcase
		return seg;
	endfunction

endpackage

//--- ps2_rx.sv
`timescale 1ns/10ps

module ps2_rx
	import ps2_pkg::*;
(
	input  logic       clk,
	input  logic       resetn,
	input  logic       ps2_clk,
	input  logic       ps2_data,
	output logic       byte_valid,
	output logic [7:0] rx_byte,
	output logic       frame_err
);

	logic [1:0]  clk_sync;
	logic        clk_last;
	logic        fall;
	logic [1:0]  data_sync;
	logic [10:0] frame;
	logic [3:0]  bit_cnt;
	logic [15:0] idle_cnt;
	logic        frame_ok;

	always_ff @(posedge clk) begin
		if (!resetn) begin
			clk_sync <= 2'b11;	// the line idles high.
			clk_last <= 1'b1;
		end else begin
			clk_sync <= {clk_sync[0], ps2_clk};
			clk_last <= clk_sync[1];
		end
	end

	// data goes through the same two stages so it lines up with the clock.
	always_ff @(posedge clk) begin
		data_sync <= {data_sync[0], ps2_data};
	end

	assign fall = clk_last & ~clk_sync[1];

	// bits arrive lsb first, so after eleven shifts the start bit sits in frame[0].
	always_ff @(posedge clk) begin
		if (fall) begin
			frame <= {data_sync[1], frame[10:1]};
		end
	end

	assign frame_ok = ~frame[0] & (^frame[9:1]) & frame[10];
	assign rx_byte = frame[8:1];

	always_ff @(posedge clk) begin
		if (!resetn) begin
			bit_cnt <= 4'd0;
			idle_cnt <= 16'd0;
			byte_valid <= 1'b0;
			frame_err <= 1'b0;
		end else begin
			byte_valid <= 1'b0;
			frame_err <= 1'b0;
			if (bit_cnt == frame_bits) begin
				// whole frame is in, check it one cycle after the last edge.
				byte_valid <= frame_ok;
				frame_err <= ~frame_ok;
				bit_cnt <= 4'd0;
				idle_cnt <= 16'd0;
			end else if (fall) begin
				bit_cnt <= bit_cnt + 4'd1;
				idle_cnt <= 16'd0;
			end else if (bit_cnt != 4'd0) begin
				if (idle_cnt == idle_timeout - 16'd1) begin
					bit_cnt <= 4'd0;	// keyboard went quiet mid frame.
					idle_cnt <= 16'd0;
				end else begin
					idle_cnt <= idle_cnt + 16'd1;
				end
			end
		end
	end

endmodule

//--- key_tracker.sv
`timescale 1ns/10ps

module key_tracker
	import ps2_pkg::*;
(
	input  logic       clk,
	input  logic       resetn,
	input  logic       byte_valid,
	input  logic [7:0] rx_byte,
	output logic       key_valid,
	output logic       key_held,
	output logic [7:0] held_code,
	output logic [7:0] ascii,
	output logic [7:0] key_count
);

	logic [1:0] state;
	logic       ext_flag;	// set by e0, kept through a following f0.
	logic       held_ext;
	logic       code_byte;
	logic       new_press;
	logic       is_release;

	// after f0 every byte is the code being released, prefix values included.
	assign code_byte = byte_valid &&
		(state == st_break || (rx_byte != ext_code && rx_byte != break_code));

	// a make code only counts as a press when it is not the held key repeating.
	assign new_press = code_byte && state != st_break &&
		(!key_held || rx_byte != held_code || ext_flag != held_ext);

	assign is_release = code_byte && state == st_break && key_held &&
		rx_byte == held_code && ext_flag == held_ext;

	always_ff @(posedge clk) begin
		if (!resetn) begin
			state <= st_idle;
			ext_flag <= 1'b0;
		end else if (byte_valid) begin
			if (!code_byte) begin
				if (rx_byte == ext_code) begin
					state <= st_ext;
					ext_flag <= 1'b1;
				end else begin
					state <= st_break;	// ext_flag keeps its value.
				end
			end else begin
				ext_flag <= 1'b0;
				if (new_press || (key_held && !is_release)) begin
					state <= st_held;
				end else begin
					state <= st_idle;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			key_valid <= 1'b0;
			key_held <= 1'b0;
			held_code <= 8'h00;
			held_ext <= 1'b0;
			ascii <= 8'h00;
			key_count <= 8'h00;
		end else begin
			key_valid <= new_press;
			if (new_press) begin
				key_held <= 1'b1;
				held_code <= rx_byte;
				held_ext <= ext_flag;
				ascii <= ext_flag ? 8'h00 : scan_to_ascii(rx_byte);	// no ascii for e0 keys.
				key_count <= key_count + 8'd1;
			end else if (is_release) begin
				key_held <= 1'b0;
				held_code <= 8'h00;
				held_ext <= 1'b0;
				ascii <= 8'h00;
			end
		end
	end

endmodule

//--- seg_display.sv
`timescale 1ns/10ps

module seg_display
	import disp_pkg::*;
(
	input  logic       clk,
	input  logic       resetn,
	input  logic       key_held,
	input  logic [7:0] held_code,
	input  logic [7:0] ascii,
	input  logic [7:0] key_count,
	output logic [6:0] hex0,
	output logic [6:0] hex1,
	output logic [6:0] hex2,
	output logic [6:0] hex3,
	output logic [6:0] hex4,
	output logic [6:0] hex5
);

	logic [6:0] digit_d [num_digits];
	logic [6:0] digit_q [num_digits];

	// digit 0 is the rightmost one.
	always_comb begin
		digit_d[0] = hex_to_seg(key_count[3:0]);
		digit_d[1] = hex_to_seg(key_count[7:4]);
		digit_d[2] = key_held ? hex_to_seg(held_code[3:0]) : seg_blank;
		digit_d[3] = key_held ? hex_to_seg(held_code[7:4]) : seg_blank;
		digit_d[4] = key_held ? hex_to_seg(ascii[3:0]) : seg_blank;
		digit_d[5] = key_held ? hex_to_seg(ascii[7:4]) : seg_blank;
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			for (int i = 0; i < num_digits; i++) begin
				// the count digits show zero, the rest stay dark.
				digit_q[i] <= (i < 2) ? hex_to_seg(4'h0) : seg_blank;
			end
		end else begin
			digit_q <= digit_d;
		end
	end

	assign hex0 = digit_q[0];
	assign hex1 = digit_q[1];
	assign hex2 = digit_q[2];
	assign hex3 = digit_q[3];
	assign hex4 = digit_q[4];
	assign hex5 = digit_q[5];

endmodule

//--- ps2_keyboard.sv
`timescale 1ns/10ps

module ps2_keyboard (
	input  logic       clk,
	input  logic       resetn,
	input  logic       ps2_clk,
	input  logic       ps2_data,
	output logic       key_valid,
	output logic [7:0] ascii,
	output logic [7:0] key_count,
	output logic       frame_err,
	output logic [6:0] hex0,
	output logic [6:0] hex1,
	output logic [6:0] hex2,
	output logic [6:0] hex3,
	output logic [6:0] hex4,
	output logic [6:0] hex5
);

	logic       byte_valid;
	logic [7:0] rx_byte;
	logic       key_held;
	logic [7:0] held_code;

	ps2_rx i_ps2_rx (
		.clk        (clk),
		.resetn     (resetn),
		.ps2_clk    (ps2_clk),
		.ps2_data   (ps2_data),
		.byte_valid (byte_valid),
		.rx_byte    (rx_byte),
		.frame_err  (frame_err)
	);

	key_tracker i_key_tracker (
		.clk        (clk),
		.resetn     (resetn),
		.byte_valid (byte_valid),
		.rx_byte    (rx_byte),
		.key_valid  (key_valid),
		.key_held   (key_held),
		.held_code  (held_code),
		.ascii      (ascii),
		.key_count  (key_count)
	);

	seg_display i_seg_display (
		.clk       (clk),
		.resetn    (resetn),
		.key_held  (key_held),
		.held_code (held_code),
		.ascii     (ascii),
		.key_count (key_count),
		.hex0      (hex0),
		.hex1      (hex1),
		.hex2      (hex2),
		.hex3      (hex3),
		.hex4      (hex4),
		.hex5      (hex5)
	);

endmodule

//--- tb_clock.sv
`timescale 1ns/10ps

module tb_clock #(
	parameter int half_period = 50	// in ns, gives a 100 ns period.
) (
	output logic clk
);

	initial begin
		clk = 1'b0;
	end

	always begin
		#half_period;
		clk = ~clk;
	end

endmodule

//--- ps2_keyboard_props.sv
`timescale 1ns/10ps

module ps2_keyboard_props (
	input logic       clk,
	input logic       resetn,
	input logic       byte_valid,
	input logic       frame_err,
	input logic       key_valid,
	input logic [7:0] key_count
);

	// the receiver either accepts or rejects a frame, never both.
	strobe_exclusive: assert property (@(posedge clk) disable iff (!resetn)
		!(byte_valid && frame_err))
		else $error("byte_valid and frame_err were high in the same cycle");

	press_after_byte: assert property (@(posedge clk) disable iff (!resetn)
		key_valid |-> $past(byte_valid))
		else $error("key_valid was high without a byte_valid in the cycle before");

	count_on_press: assert property (@(posedge clk) disable iff (!resetn)
		($past(key_count) != key_count) |-> key_valid)
		else $error("key_count changed in a cycle without key_valid");

	quiet_after_reset: assert property (@(posedge clk)
		$rose(resetn) |=> !key_valid)
		else $error("key_valid was high right after reset was released");

endmodule

bind ps2_keyboard ps2_keyboard_props i_ps2_keyboard_props (
	.clk        (clk),
	.resetn     (resetn),
	.byte_valid (byte_valid),
	.frame_err  (frame_err),
	.key_valid  (key_valid),
	.key_count  (key_count)
);

//--- ps2_keyboard_tb.sv
`timescale 1ns/10ps

module ps2_keyboard_tb
	import ps2_pkg::*, disp_pkg::*;
();

	localparam int half_bit = 20;	// clk cycles per half of a ps/2 bit.
	localparam int frame_gap = 10;
	localparam int settle_cycles = 10;
	localparam int strobe_timeout = 100;
	localparam int planned_frames = 140;
	localparam int num_keys = 12;

	// keys used by the tests and the character each one should give.
	localparam logic [7:0] key_code [num_keys] = '{8'h1c, 8'h32, 8'h21, 8'h2b, 8'h1a, 8'h4d,
		8'h45, 8'h16, 8'h3e, 8'h46, 8'h29, 8'h5a};
	localparam logic [7:0] key_char [num_keys] = '{8'h61, 8'h62, 8'h63, 8'h66, 8'h7a, 8'h70,
		8'h30, 8'h31, 8'h38, 8'h39, 8'h20, 8'h0d};

	logic        clk;
	logic        resetn;
	logic        ps2_clk;
	logic        ps2_data;
	logic        key_valid;
	logic        frame_err;
	logic [7:0]  ascii;
	logic [7:0]  key_count;
	logic [6:0]  hex0;
	logic [6:0]  hex1;
	logic [6:0]  hex2;
	logic [6:0]  hex3;
	logic [6:0]  hex4;
	logic [6:0]  hex5;

	int          press_seen;
	int          err_seen;
	logic        kv_q;
	logic [7:0]  snap_ascii;
	logic [7:0]  snap_count;
	logic [41:0] snap_hex;

	// reference model of the key tracker.
	logic        m_held;
	logic        m_ext_held;
	logic        m_brk;
	logic        m_ext;
	logic [7:0]  m_code;
	logic [7:0]  m_ascii;
	logic [7:0]  m_count;

	tb_clock i_tb_clock (.clk(clk));

	ps2_keyboard i_ps2_keyboard (
		.clk       (clk),
		.resetn    (resetn),
		.ps2_clk   (ps2_clk),
		.ps2_data  (ps2_data),
		.key_valid (key_valid),
		.ascii     (ascii),
		.key_count (key_count),
		.frame_err (frame_err),
		.hex0      (hex0),
		.hex1      (hex1),
		.hex2      (hex2),
		.hex3      (hex3),
		.hex4      (hex4),
		.hex5      (hex5)
	);

	// counts strobes and keeps what the outputs showed around each press.
	always @(posedge clk) begin
		if (!resetn) begin
			press_seen <= 0;
			err_seen <= 0;
			kv_q <= 1'b0;
		end else begin
			if (key_valid) begin
				press_seen <= press_seen + 1;
				snap_ascii <= ascii;
				snap_count <= key_count;
			end
			if (frame_err) begin
				err_seen <= err_seen + 1;
			end
			if (kv_q) begin
				snap_hex <= {hex5, hex4, hex3, hex2, hex1, hex0};	// one cycle after the press.
			end
			kv_q <= key_valid;
		end
	end

	task automatic stop_run(input string why);
		$display("%s", why);
		$display("*** TEST FAILED ***");
		$fatal(1, "stopping at the first error");
	endtask

	task automatic mismatch(input string msg);
		stop_run($sformatf("MISMATCH at %0d ns: %s", $time, msg));
	endtask

	function automatic logic [7:0] ref_ascii(input logic [7:0] code);
		logic [7:0] ch;
		ch = 8'h00;
		for (int i = 0; i < num_keys; i++) begin
			if (key_code[i] == code) begin
				ch = key_char[i];
			end
		end
		return ch;
	endfunction

	function automatic logic [41:0] exp_digits();
		logic [6:0] d5;
		logic [6:0] d4;
		logic [6:0] d3;
		logic [6:0] d2;
		d5 = m_held ? hex_to_seg(m_ascii[7:4]) : seg_blank;
		d4 = m_held ? hex_to_seg(m_ascii[3:0]) : seg_blank;
		d3 = m_held ? hex_to_seg(m_code[7:4]) : seg_blank;
		d2 = m_held ? hex_to_seg(m_code[3:0]) : seg_blank;
		return {d5, d4, d3, d2, hex_to_seg(m_count[7:4]), hex_to_seg(m_count[3:0])};
	endfunction

	// applies one received byte to the model and tells whether it is a new press.
	task automatic model_byte(input logic [7:0] data, output bit pressed);
		pressed = 1'b0;
		if (!m_brk && data == ext_code) begin
			m_ext = 1'b1;
		end else if (!m_brk && data == break_code) begin
			m_brk = 1'b1;
		end else begin
			if (m_brk) begin
				if (m_held && data == m_code && m_ext == m_ext_held) begin
					m_held = 1'b0;
					m_ext_held = 1'b0;
					m_code = 8'h00;
					m_ascii = 8'h00;
				end
			end else if (!m_held || data != m_code || m_ext != m_ext_held) begin
				pressed = 1'b1;
				m_held = 1'b1;
				m_ext_held = m_ext;
				m_code = data;
				m_ascii = m_ext ? 8'h00 : ref_ascii(data);
				m_count = m_count + 8'd1;
			end
			m_brk = 1'b0;
			m_ext = 1'b0;
		end
	endtask

	// start bit, eight data bits lsb first, odd parity, stop bit.
	task automatic send_frame(input logic [7:0] data, input logic bad_parity,
		input logic bad_stop);
		logic [10:0] bits;
		bits = {~bad_stop, ~(^data) ^ bad_parity, data, 1'b0};
		for (int i = 0; i < 11; i++) begin
			@(posedge clk);
			ps2_data <= bits[i];
			repeat (half_bit) @(posedge clk);
			ps2_clk <= 1'b0;
			repeat (half_bit) @(posedge clk);
			ps2_clk <= 1'b1;
		end
		repeat (frame_gap) @(posedge clk);
	endtask

	task automatic wait_strobe(input bit want_err, input int target);
		int waited;
		waited = 0;
		while ((want_err ? err_seen : press_seen) < target && waited < strobe_timeout) begin
			@(posedge clk);
			waited++;
		end
		if ((want_err ? err_seen : press_seen) < target) begin
			stop_run(want_err ? "timed out waiting for frame_err" :
				"timed out waiting for key_valid");
		end
		repeat (2) @(posedge clk);
	endtask

	task automatic check_outputs();
		assert (ascii == m_ascii)
			else mismatch($sformatf("ascii is %h, expected %h", ascii, m_ascii));
		assert (key_count == m_count)
			else mismatch($sformatf("key_count is %h, expected %h", key_count, m_count));
		assert ({hex5, hex4, hex3, hex2, hex1, hex0} == exp_digits())
			else mismatch($sformatf("digits are %h, expected %h",
				{hex5, hex4, hex3, hex2, hex1, hex0}, exp_digits()));
	endtask

	task automatic send_byte(input logic [7:0] data);
		int presses;
		int errs;
		bit pressed;
		presses = press_seen;
		errs = err_seen;
		model_byte(data, pressed);
		send_frame(data, 1'b0, 1'b0);
		if (pressed) begin
			wait_strobe(1'b0, presses + 1);
			assert (snap_ascii == m_ascii)
				else mismatch($sformatf("ascii at key_valid is %h, expected %h",
					snap_ascii, m_ascii));
			assert (snap_count == m_count)
				else mismatch($sformatf("key_count at key_valid is %h, expected %h",
					snap_count, m_count));
			assert (snap_hex == exp_digits())
				else mismatch($sformatf("digits after key_valid are %h, expected %h",
					snap_hex, exp_digits()));
		end else begin
			repeat (settle_cycles) @(posedge clk);
		end
		assert (press_seen == presses + (pressed ? 1 : 0))
			else mismatch($sformatf("key_valid pulsed %0d times for byte %h",
				press_seen - presses, data));
		assert (err_seen == errs)
			else mismatch($sformatf("frame_err pulsed for good byte %h", data));
		check_outputs();
	endtask

	task automatic send_bad_frame(input logic [7:0] data, input logic bad_parity,
		input logic bad_stop);
		int presses;
		int errs;
		presses = press_seen;
		errs = err_seen;
		send_frame(data, bad_parity, bad_stop);
		wait_strobe(1'b1, errs + 1);
		assert (err_seen == errs + 1)
			else mismatch($sformatf("frame_err pulsed %0d times", err_seen - errs));
		assert (press_seen == presses)
			else mismatch("key_valid pulsed for a corrupted frame");
		check_outputs();
	endtask

	task automatic check_reset_state();
		assert (key_valid == 1'b0) else mismatch("key_valid high after reset");
		assert (frame_err == 1'b0) else mismatch("frame_err high after reset");
		assert (key_count == 8'h00)
			else mismatch($sformatf("key_count is %h after reset", key_count));
		assert ({hex5, hex4, hex3, hex2} == {4{seg_blank}})
			else mismatch("upper four digits are not blank after reset");
		assert (hex1 == hex_to_seg(4'h0) && hex0 == hex_to_seg(4'h0))
			else mismatch("count digits do not show zero after reset");
	endtask

	task automatic press_and_release_keys();
		for (int i = 0; i < num_keys; i++) begin
			send_byte(key_code[i]);
			assert (ascii == key_char[i])
				else mismatch($sformatf("key %h gave ascii %h", key_code[i], ascii));
			send_byte(break_code);
			send_byte(key_code[i]);
		end
	endtask

	task automatic typematic_repeat();
		logic [7:0] start_count;
		start_count = m_count;
		repeat (5) send_byte(key_code[0]);
		assert (key_count == start_count + 8'd1)
			else mismatch("repeated make code changed the count more than once");
		send_byte(key_code[4]);	// second key takes over the display.
		send_byte(break_code);
		send_byte(key_code[4]);
		send_byte(break_code);
		send_byte(key_code[0]);
	endtask

	task automatic corrupted_frames();
		send_bad_frame(key_code[2], 1'b1, 1'b0);
		send_bad_frame(key_code[2], 1'b0, 1'b1);
		send_byte(key_code[2]);
		send_byte(break_code);
		send_byte(key_code[2]);
	endtask

	task automatic extended_keys();
		send_byte(ext_code);
		send_byte(key_code[0]);
		assert (ascii == 8'h00) else mismatch("extended key gave a nonzero ascii");
		send_byte(break_code);	// plain release must not free the extended key.
		send_byte(key_code[0]);
		send_byte(ext_code);
		send_byte(break_code);
		send_byte(key_code[0]);
	endtask

	task automatic random_sequence();
		int idx;
		int kind;
		for (int n = 0; n < 40; n++) begin
			idx = int'($urandom % num_keys);
			kind = int'($urandom % 3);
			if (kind == 1 && m_held) begin
				send_byte(m_code);
			end else if (kind == 2) begin
				send_byte(break_code);
				send_byte(m_held ? m_code : key_code[idx]);
			end else begin
				send_byte(key_code[idx]);
			end
		end
	endtask

	initial begin
		void'($urandom(32'h83240937));
		resetn <= 1'b0;
		ps2_clk <= 1'b1;	// both lines idle high.
		ps2_data <= 1'b1;
		m_held = 1'b0;
		m_ext_held = 1'b0;
		m_brk = 1'b0;
		m_ext = 1'b0;
		m_code = 8'h00;
		m_ascii = 8'h00;
		m_count = 8'h00;
		repeat (3) @(posedge clk);
		resetn <= 1'b1;
		@(posedge clk);
		check_reset_state();
		press_and_release_keys();
		typematic_repeat();
		corrupted_frames();
		extended_keys();
		random_sequence();
		$display("*** TEST PASSED ***");
		$finish;
	end

	initial begin
		repeat (planned_frames * 500 + 5000) @(posedge clk);
		stop_run("watchdog expired before the tests finished");
	end

endmodule

//--- ps2_keyboard.f
ps2_pkg.sv
disp_pkg.sv
ps2_rx.sv
key_tracker.sv
seg_display.sv
ps2_keyboard.sv
tb_clock.sv
ps2_keyboard_props.sv
ps2_keyboard_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := ps2_keyboard_tb
FILELIST  := ps2_keyboard.f
BUILD     := obj_dir
LOG       := sim.log
FAIL_MSG  := *** TEST FAILED ***
PASS_MSG  := *** TEST PASSED ***

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

run: compile
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -qF '$(FAIL_MSG)' $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi
	@if ! grep -qF '$(PASS_MSG)' $(LOG); then \
		echo "simulation ended without passing, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)
